//--- hdl/booth_controller.sv
`timescale 1ns/1ps

module booth_controller (
    input  logic                clk,
    input  logic                rst,
    input  logic                src_valid,
    input  logic                dest_ready,
    input  logic                last_step,
    input  logic [1:0]          booth_bits,
    output logic                src_ready,
    output logic                dest_valid,
    output logic                load,
    output logic                step,
    output mult_pkg::booth_op_t op
);

    mult_pkg::booth_state_t state;
    mult_pkg::booth_state_t next_state;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= mult_pkg::st_start;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            mult_pkg::st_start: begin
                if (src_valid) begin
                    next_state = mult_pkg::st_process;
                end
            end
            mult_pkg::st_process: begin
                // Leave after the final step has been applied.
                if (last_step) begin
                    next_state = mult_pkg::st_wait_out;
                end
            end
            mult_pkg::st_wait_out: begin
                if (dest_ready) begin
                    next_state = mult_pkg::st_done;
                end
            end
            mult_pkg::st_done: begin
                next_state = mult_pkg::st_start;
            end
            default: begin
                next_state = mult_pkg::st_start;
            end
        endcase
    end

    assign src_ready  = (state == mult_pkg::st_start);
    assign load       = src_ready && src_valid;
    assign step       = (state == mult_pkg::st_process);

    // Product register is final only once in wait_out.
    assign dest_valid = (state == mult_pkg::st_wait_out);

    // Radix-2 recoding of the current bit and the one shifted out.
    always_comb begin
        op = mult_pkg::op_skip;
        if (step) begin
            case (booth_bits)
                2'b01:   op = mult_pkg::op_add;
                2'b10:   op = mult_pkg::op_sub;
                default: op = mult_pkg::op_skip;
            endcase
        end
    end

endmodule

//--- hdl/booth_lane.sv
`timescale 1ns/1ps

module booth_lane #(
    parameter int WIDTH = 16,
    parameter int TAG_W = 4
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     src_valid,
    output logic                     src_ready,
    input  logic [WIDTH-1:0]         a,
    input  logic [WIDTH-1:0]         b,
    input  logic [TAG_W-1:0]         tag,
    output logic                     dest_valid,
    input  logic                     dest_ready,
    output logic [TAG_W+2*WIDTH-1:0] payload
);

    localparam int CNT_W = (WIDTH > 1) ? $clog2(WIDTH) : 1;

    logic                load;
    logic                step;
    logic                last_step;
    mult_pkg::booth_op_t op;

    logic [WIDTH-1:0]    mcand;
    logic [TAG_W-1:0]    tag_q;
    logic [CNT_W-1:0]    count;

    // Accumulator (one guard bit), multiplier, then the extra low bit.
    logic [2*WIDTH+1:0]  acc_mult;
    logic [WIDTH:0]      acc_ext;
    logic [WIDTH:0]      mcand_ext;
    logic [WIDTH:0]      acc_next;
    logic [2*WIDTH+1:0]  shifted;

    assign acc_ext   = acc_mult[2*WIDTH+1:WIDTH+1];
    assign mcand_ext = {mcand[WIDTH-1], mcand};

    always_comb begin
        case (op)
            mult_pkg::op_add: acc_next = acc_ext + mcand_ext;
            mult_pkg::op_sub: acc_next = acc_ext - mcand_ext;
            default:          acc_next = acc_ext;
        endcase
    end

    assign shifted = $signed({acc_next, acc_mult[WIDTH:0]}) >>> 1;

    always_ff @(posedge clk) begin
        if (load) begin
            mcand    <= a;
            tag_q    <= tag;
            acc_mult <= {{(WIDTH+1){1'b0}}, b, 1'b0};
        end else if (step) begin
            acc_mult <= shifted;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            count <= '0;
        end else if (load) begin
            count <= '0;
        end else if (step) begin
            count <= count + 1'b1;
        end
    end

    assign last_step = step && (count == CNT_W'(WIDTH - 1));

    assign payload = {tag_q, acc_mult[2*WIDTH:1]};

    booth_controller booth_controller_i (
        .clk        (clk),
        .rst        (rst),
        .src_valid  (src_valid),
        .dest_ready (dest_ready),
        .last_step  (last_step),
        .booth_bits (acc_mult[1:0]),
        .src_ready  (src_ready),
        .dest_valid (dest_valid),
        .load       (load),
        .step       (step),
        .op         (op)
    );

endmodule

//--- hdl/mult_cluster.sv
`timescale 1ns/1ps

module mult_cluster #(
    parameter int WIDTH = mult_pkg::DEF_WIDTH,
    parameter int TAG_W = mult_pkg::DEF_TAG_W
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    output logic               in_ready,
    input  logic [WIDTH-1:0]   in_a,
    input  logic [WIDTH-1:0]   in_b,
    input  logic [TAG_W-1:0]   in_tag,
    output logic               out_valid,
    input  logic               out_ready,
    output logic [TAG_W-1:0]   out_tag,
    output logic [2*WIDTH-1:0] out_product
);

    localparam int PAY_W = TAG_W + 2*WIDTH;

    logic [1:0]       src_valid;
    logic [1:0]       src_ready;
    logic [1:0]       dest_valid;
    logic [1:0]       dest_ready;
    logic [PAY_W-1:0] payload0;
    logic [PAY_W-1:0] payload1;
    logic [PAY_W-1:0] out_payload;

    // Lane 0 first, lane 1 only when lane 0 is busy.
    assign src_valid[0] = in_valid && src_ready[0];
    assign src_valid[1] = in_valid && !src_ready[0] && src_ready[1];
    assign in_ready     = |src_ready;

    booth_lane #(
        .WIDTH (WIDTH),
        .TAG_W (TAG_W)
    ) booth_lane_0 (
        .clk        (clk),
        .rst        (rst),
        .src_valid  (src_valid[0]),
        .src_ready  (src_ready[0]),
        .a          (in_a),
        .b          (in_b),
        .tag        (in_tag),
        .dest_valid (dest_valid[0]),
        .dest_ready (dest_ready[0]),
        .payload    (payload0)
    );

    booth_lane #(
        .WIDTH (WIDTH),
        .TAG_W (TAG_W)
    ) booth_lane_1 (
        .clk        (clk),
        .rst        (rst),
        .src_valid  (src_valid[1]),
        .src_ready  (src_ready[1]),
        .a          (in_a),
        .b          (in_b),
        .tag        (in_tag),
        .dest_valid (dest_valid[1]),
        .dest_ready (dest_ready[1]),
        .payload    (payload1)
    );

    result_arbiter #(
        .PAY_W (PAY_W)
    ) result_arbiter_i (
        .clk           (clk),
        .rst           (rst),
        .lane_valid    (dest_valid),
        .lane_payload0 (payload0),
        .lane_payload1 (payload1),
        .lane_ready    (dest_ready),
        .out_valid     (out_valid),
        .out_ready     (out_ready),
        .out_payload   (out_payload)
    );

    assign out_tag     = out_payload[PAY_W-1 -: TAG_W];
    assign out_product = out_payload[2*WIDTH-1:0];

endmodule

//--- hdl/mult_pkg.sv
package mult_pkg;

    // Default sizes for the cluster.
    localparam int DEF_WIDTH = 16;
    localparam int DEF_TAG_W = 4;

    // Lane sequencing states.
    typedef enum logic [1:0] {
        st_start    = 2'b00,
        st_process  = 2'b01,
        st_wait_out = 2'b10,
        st_done     = 2'b11
    } booth_state_t;

    // Action taken on the upper half for one Booth step.
    typedef enum logic [1:0] {
        op_skip = 2'b00,
        op_add  = 2'b01,
        op_sub  = 2'b10
    } booth_op_t;

endpackage

//--- hdl/result_arbiter.sv
`timescale 1ns/1ps

module result_arbiter #(
    parameter int PAY_W = 36
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [1:0]       lane_valid,
    input  logic [PAY_W-1:0] lane_payload0,
    input  logic [PAY_W-1:0] lane_payload1,
    output logic [1:0]       lane_ready,
    output logic             out_valid,
    input  logic             out_ready,
    output logic [PAY_W-1:0] out_payload
);

    logic ptr;
    logic locked;
    logic held;
    logic pick;
    logic grant;

    // Pointer decides only when both lanes compete.
    assign pick  = (&lane_valid) ? ptr : lane_valid[1];

    // A stalled grant is kept until it transfers.
    assign grant = locked ? held : pick;

    assign out_valid   = |lane_valid;
    assign out_payload = grant ? lane_payload1 : lane_payload0;
    assign lane_ready  = {out_ready && out_valid && grant,
                          out_ready && out_valid && !grant};

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ptr    <= 1'b0;
            locked <= 1'b0;
            held   <= 1'b0;
        end else begin
            if (out_valid && out_ready) begin
                ptr <= ~grant;
            end
            locked <= out_valid && !out_ready;
            held   <= grant;
        end
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f vlog.f \
    --top-module tb_mult_cluster -o tb_mult_cluster
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output="$(./obj_dir/tb_mult_cluster)"
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -qx "sim passed"; then
    exit 0
fi
exit 1

//--- verification/mult_tests.txt
// Columns in hex: tag, multiplicand, multiplier, expected signed product.
// Operands are 16 bits, products 32 bits.
0 0000 0000 00000000
1 0000 7fff 00000000
2 ffff ffff 00000001
3 8000 8000 40000000
4 7fff 8000 c0008000
5 7fff 7fff 3fff0001
6 ffff 7fff ffff8001
7 8000 ffff 00008000
8 0001 8000 ffff8000
9 0001 0001 00000001
a 0002 0003 00000006
b fffe 0003 fffffffa
c fffd fffc 0000000c
d 0010 0010 00000100
e 0100 ff00 ffff0000
f 1234 0010 00012340
0 1234 fff0 fffedcc0
1 00ff 00ff 0000fe01
2 ff01 00ff ffff01ff
3 ff01 ff01 0000fe01
4 5555 0003 0000ffff
5 aaab 0003 ffff0001
6 c000 c000 10000000
7 4000 fffc ffff0000
8 0064 ff9c ffffd8f0
9 03e8 03e8 000f4240
a fc18 03e8 fff0bdc0
b 0007 fff9 ffffffcf
c 8001 7fff c000ffff
d 0aaa 0005 00003552
e ffff 0000 00000000
f 8000 0000 00000000

//--- verification/result_checker.sv
`timescale 1ns/1ps

module result_checker #(
    parameter int WIDTH = 16,
    parameter int TAG_W = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               in_valid,
    input  logic               in_ready,
    input  logic               out_valid,
    input  logic               out_ready,
    input  logic [TAG_W-1:0]   out_tag,
    input  logic [2*WIDTH-1:0] out_product,
    output int                 seen_count
);

    localparam int NTAGS = 1 << TAG_W;

    logic [2*WIDTH-1:0] expected [NTAGS];
    int                 issue_cnt [NTAGS] = '{default: 0};
    int                 done_cnt [NTAGS] = '{default: 0};
    int                 num_pass = 0;
    int                 num_fail = 0;
    int                 num_other = 0;
    int                 num_seen = 0;
    int                 in_flight = 0;
    bit                 saw_two = 1'b0;
    bit                 stalled = 1'b0;
    logic [TAG_W-1:0]   held_tag;
    logic [2*WIDTH-1:0] held_product;

    assign seen_count = num_seen;

    function automatic logic tag_busy(input logic [TAG_W-1:0] tag);
        return issue_cnt[tag] != done_cnt[tag];
    endfunction

    task automatic expect_result(input logic [TAG_W-1:0] tag, input logic [2*WIDTH-1:0] product);
        expected[tag]  = product;
        issue_cnt[tag] = issue_cnt[tag] + 1;
    endtask

    always @(posedge clk) begin
        if (rst) begin
            // Nothing in flight means an idle, ready cluster.
            if (in_flight == 0 && (!in_ready || out_valid)) begin
                $display("%0t: cluster not idle with nothing in flight", $time);
                num_other = num_other + 1;
            end
            if (stalled && !out_valid) begin
                $display("%0t: out_valid dropped during a stall on tag %h", $time, held_tag);
                num_other = num_other + 1;
            end else if (stalled && (out_tag != held_tag || out_product != held_product)) begin
                $display("MISMATCH at %0t: output changed during a stall, tag %h product %h",
                         $time, held_tag, held_product);
                num_other = num_other + 1;
            end
            if (out_valid && out_ready) begin
                if (issue_cnt[out_tag] == done_cnt[out_tag]) begin
                    $display("%0t: result for tag %h which is not outstanding", $time, out_tag);
                    num_other = num_other + 1;
                end else if (out_product === expected[out_tag]) begin
                    $display("PASS tag %h product %h at %0t", out_tag, out_product, $time);
                    num_pass = num_pass + 1;
                end else begin
                    $display("MISMATCH at %0t: tag %h expected %h got %h",
                             $time, out_tag, expected[out_tag], out_product);
                    num_fail = num_fail + 1;
                end
                done_cnt[out_tag] = issue_cnt[out_tag];
                num_seen  = num_seen + 1;
                in_flight = in_flight - 1;
            end
            if (in_valid && in_ready) begin
                in_flight = in_flight + 1;
            end
            if (in_flight >= 2) begin
                saw_two = 1'b1;
            end
            stalled      = out_valid && !out_ready;
            held_tag     = out_tag;
            held_product = out_product;
        end
    end

    task automatic finish_report(output int errors);
        int stuck;
        stuck = 0;
        for (int t = 0; t < NTAGS; t++) begin
            if (issue_cnt[t] != done_cnt[t]) begin
                $display("tag %0d is still outstanding at the end of the run", t);
                stuck = stuck + 1;
            end
        end
        if (!saw_two) begin
            $display("two operations were never in flight at the same time");
            stuck = stuck + 1;
        end
        errors = num_fail + num_other + stuck;
        $display("results: %0d passed, %0d failed, %0d other errors",
                 num_pass, num_fail, num_other + stuck);
    endtask

endmodule

//--- verification/tb_mult_cluster.sv
`timescale 1ns/1ps

module tb_mult_cluster;

    localparam int    WIDTH        = mult_pkg::DEF_WIDTH;
    localparam int    TAG_W        = mult_pkg::DEF_TAG_W;
    localparam int    RESET_CYCLES = 16;
    localparam string TEST_FILE    = "verification/mult_tests.txt";

    logic               clk = 1'b0;
    logic               rst;
    logic               in_valid;
    logic               in_ready;
    logic [WIDTH-1:0]   in_a;
    logic [WIDTH-1:0]   in_b;
    logic [TAG_W-1:0]   in_tag;
    logic               out_valid;
    logic               out_ready = 1'b1;
    logic [TAG_W-1:0]   out_tag;
    logic [2*WIDTH-1:0] out_product;

    logic [TAG_W-1:0]   test_tag [$];
    logic [WIDTH-1:0]   test_a [$];
    logic [WIDTH-1:0]   test_b [$];
    logic [2*WIDTH-1:0] test_product [$];

    int          seen_count;
    int          cycles = 0;
    int          cycle_limit = 0;
    int          errors;

    always #50 clk = ~clk;

    // Output stalls on roughly one falling edge in three.
    initial begin
        void'($urandom(96));
        forever begin
            @(negedge clk);
            out_ready <= ($urandom % 3) != 0;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("sim failed");
            $finish;
        end
    end

    mult_cluster #(
        .WIDTH (WIDTH),
        .TAG_W (TAG_W)
    ) mult_cluster_i (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .in_a        (in_a),
        .in_b        (in_b),
        .in_tag      (in_tag),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_tag     (out_tag),
        .out_product (out_product)
    );

    result_checker #(
        .WIDTH (WIDTH),
        .TAG_W (TAG_W)
    ) result_checker_i (
        .clk         (clk),
        .rst         (rst),
        .in_valid    (in_valid),
        .in_ready    (in_ready),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_tag     (out_tag),
        .out_product (out_product),
        .seen_count  (seen_count)
    );

    // Entered and left on a falling edge.
    task automatic send_tests();
        bit accepted;
        for (int i = 0; i < test_tag.size(); i++) begin
            while (result_checker_i.tag_busy(test_tag[i])) begin
                @(negedge clk);
            end
            result_checker_i.expect_result(test_tag[i], test_product[i]);
            in_valid = 1'b1;
            in_a     = test_a[i];
            in_b     = test_b[i];
            in_tag   = test_tag[i];
            // in_ready only moves on a rising edge.
            do begin
                accepted = in_ready;
                @(negedge clk);
            end while (!accepted);
            in_valid = 1'b0;
        end
    endtask

    initial begin
        int               fd;
        int               code;
        string            line;
        logic [TAG_W-1:0] t;
        logic [WIDTH-1:0] a;
        logic [WIDTH-1:0] b;
        logic [2*WIDTH-1:0] p;
        rst        = 1'b0;
        in_valid   = 1'b0;
        in_a       = '0;
        in_b       = '0;
        in_tag     = '0;
        fd = $fopen(TEST_FILE, "r");
        while (fd != 0 && !$feof(fd)) begin
            code = $fgets(line, fd);
            if (code > 0 && $sscanf(line, "%h %h %h %h", t, a, b, p) == 4) begin
                test_tag.push_back(t);
                test_a.push_back(a);
                test_b.push_back(b);
                test_product.push_back(p);
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        cycle_limit = test_tag.size() * (WIDTH + 4) * 4 + 200;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b1;
        if (test_tag.size() == 0) begin
            $display("no tests could be read from %s", TEST_FILE);
            $display("sim failed");
            $finish;
        end else begin
            send_tests();
            while (seen_count < test_tag.size()) begin
                @(negedge clk);
            end
            repeat (2) @(negedge clk);
            result_checker_i.finish_report(errors);
            if (errors == 0) begin
                $display("sim passed");
            end else begin
                $display("sim failed");
            end
            $finish;
        end
    end

endmodule

//--- vlog.f
hdl/mult_pkg.sv
hdl/booth_controller.sv
hdl/booth_lane.sv
hdl/result_arbiter.sv
hdl/mult_cluster.sv
verification/result_checker.sv
verification/tb_mult_cluster.sv
